/* Bender.yml */
package:
  name: timer_subsystem

sources:
  # Shared package
  - common/timer_pkg.sv
  # RTL
  - design/timestamp_gen.sv
  - design/timer_tick.sv
  - timer/timer_channel.sv
  - timer/timer_bank.sv
  - design/timer_top.sv
  # Testbench
  - target: simulation
    files:
      - sim/tb_timer_top.sv

/* common/timer_pkg.sv */
`default_nettype none

package timer_pkg;

    // --------------------
    // Timebase
    // --------------------

    // Free-running clk-cycle timestamp width
    localparam int TS_WID = 32;

    // Timestamp bit used as tclk
    // Bit 1 toggles every 2 clk cycles, one DDR event each time
    localparam int TCLK_BIT = 1;

    // --------------------
    // Tick generators
    // --------------------

    // tclk events per fine tick, 10 clk cycles
    localparam int FINE_DIV = 5;

    // tclk events per coarse tick, 40 clk cycles
    localparam int COARSE_DIV = 20;

    // --------------------
    // Countdown timers
    // --------------------

    // Number of channels in the bank
    localparam int NUM_TIMERS = 4;

    // Load count width
    localparam int TMR_CNT_WID = 8;

    // Channel index width
    localparam int TMR_ID_WID = $clog2(NUM_TIMERS);

    // Smallest count a channel runs with, a load of 0 is raised to this
    localparam int TMR_CNT_MIN = 1;

    // Value types
    typedef logic [TS_WID-1:0]      ts_t;
    typedef logic [TMR_CNT_WID-1:0] tmr_cnt_t;
    typedef logic [TMR_ID_WID-1:0]  tmr_id_t;
    typedef logic [NUM_TIMERS-1:0]  tmr_vec_t;

    // Tick source, 0 = fine, 1 = coarse
    typedef logic tick_sel_t;

    // Timer command, valid with cmd_valid
    typedef struct packed {
        tmr_id_t   id;
        logic      stop;
        tick_sel_t tick_sel;
        tmr_cnt_t  count;
    } tmr_cmd_t;

    // Channel state
    typedef enum logic {
        TMR_IDLE = 1'b0,
        TMR_RUN  = 1'b1
    } tmr_state_e;

endpackage : timer_pkg

`default_nettype wire

/* compile.f */
common/timer_pkg.sv
design/timestamp_gen.sv
design/timer_tick.sv
timer/timer_channel.sv
timer/timer_bank.sv
design/timer_top.sv
sim/tb_timer_top.sv

/* design/timer_tick.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_tick #(
    // tclk events per output tick
    // 1 passes every event, 0 ticks on every clk cycle
    parameter int TCLK_PER_TICK = 10,
    // 1 counts both tclk edges, 0 rising edges only
    parameter bit TCLK_DDR      = 1'b1
) (
    input  logic clk,
    input  logic srst,

    // Holds tick low, counting goes on
    input  logic squelch,

    // Slow timer clock, sampled on clk
    input  logic tclk,

    // One-cycle timer tick
    output logic tick
);

    // --------------------
    // Signals
    // --------------------

    logic tclk_reg;
    logic tclk_event;
    logic tclk_pulse;
    logic tick_int;

    // --------------------
    // Edge detect
    // --------------------

    // Previous tclk sample
    always_ff @(posedge clk) begin
        if (srst) begin
            tclk_reg <= 1'b0;
        end else begin
            tclk_reg <= tclk;
        end
    end

    // Any change in DDR mode, else rising edge only
    assign tclk_event = TCLK_DDR ? (tclk != tclk_reg) : (tclk && !tclk_reg);

    // One pulse per counted edge
    always_ff @(posedge clk) begin
        if (srst) begin
            tclk_pulse <= 1'b0;
        end else begin
            tclk_pulse <= tclk_event;
        end
    end

    // --------------------
    // Divider
    // --------------------

    generate
        if (TCLK_PER_TICK > 1) begin : g_tclk_div
            localparam int CNT_WID = $clog2(TCLK_PER_TICK);
            localparam logic [CNT_WID-1:0] CNT_MAX = CNT_WID'(TCLK_PER_TICK - 1);

            logic [CNT_WID-1:0] tclk_cnt;

            // Pulse counter, wraps after the last pulse of a tick
            always_ff @(posedge clk) begin
                if (srst) begin
                    tclk_cnt <= '0;
                end else if (tclk_pulse) begin
                    tclk_cnt <= (tclk_cnt == CNT_MAX) ? '0 : tclk_cnt + 1'b1;
                end
            end

            // Tick on the wrapping pulse
            always_ff @(posedge clk) begin
                if (srst) begin
                    tick_int <= 1'b0;
                end else begin
                    tick_int <= tclk_pulse && (tclk_cnt == CNT_MAX);
                end
            end

            // Divided tick never spans two cycles
            a_tick_single : assert property (
                @(posedge clk) disable iff (srst)
                tick |=> !tick
            );
        end else if (TCLK_PER_TICK == 1) begin : g_tclk_no_div
            // Every pulse is a tick
            assign tick_int = tclk_pulse;
        end else begin : g_no_tclk
            // tclk ignored, tick on each cycle out of reset
            always_ff @(posedge clk) begin
                if (srst) begin
                    tick_int <= 1'b0;
                end else begin
                    tick_int <= 1'b1;
                end
            end
        end
    endgenerate

    // --------------------
    // Output stage
    // --------------------

    // Squelch masks only the output, so the tick phase is kept
    always_ff @(posedge clk) begin
        if (srst) begin
            tick <= 1'b0;
        end else begin
            tick <= squelch ? 1'b0 : tick_int;
        end
    end

endmodule : timer_tick

`default_nettype wire

/* design/timer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_top
    import timer_pkg::*;
(
    input  logic     clk,
    input  logic     srst,

    // Timer commands
    input  logic     cmd_valid,
    input  tmr_cmd_t cmd,

    // Holds both ticks low, pauses the timers
    input  logic     squelch,

    // Timebase
    output ts_t      timestamp,

    // Tick outputs, also feeding the bank
    output logic     fine_tick,
    output logic     coarse_tick,

    // Expiry strobes
    output tmr_vec_t expired
);

    // --------------------
    // Timebase
    // --------------------

    timestamp_gen u_timestamp_gen (
        .clk       (clk),
        .srst      (srst),
        .timestamp (timestamp)
    );

    // --------------------
    // Tick generators
    // --------------------

    // Both run DDR off the same timestamp bit
    // Fine tick every 10 cycles
    timer_tick #(
        .TCLK_PER_TICK (FINE_DIV),
        .TCLK_DDR      (1'b1)
    ) u_fine_tick (
        .clk     (clk),
        .srst    (srst),
        .squelch (squelch),
        .tclk    (timestamp[TCLK_BIT]),
        .tick    (fine_tick)
    );

    // Coarse tick every 40 cycles
    timer_tick #(
        .TCLK_PER_TICK (COARSE_DIV),
        .TCLK_DDR      (1'b1)
    ) u_coarse_tick (
        .clk     (clk),
        .srst    (srst),
        .squelch (squelch),
        .tclk    (timestamp[TCLK_BIT]),
        .tick    (coarse_tick)
    );

    // --------------------
    // Countdown timers
    // --------------------

    // Squelched ticks stall every running channel
    timer_bank u_timer_bank (
        .clk         (clk),
        .srst        (srst),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .fine_tick   (fine_tick),
        .coarse_tick (coarse_tick),
        .expired     (expired)
    );

endmodule : timer_top

`default_nettype wire

/* design/timestamp_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module timestamp_gen
    import timer_pkg::*;
(
    input  logic clk,
    input  logic srst,

    // Running clk-cycle count
    output ts_t  timestamp
);

    // --------------------
    // Counter
    // --------------------

    // Cleared in reset, plus one every cycle after
    // Wraps at the top of ts_t without any flag
    always_ff @(posedge clk) begin
        if (srst) begin
            timestamp <= '0;
        end else begin
            timestamp <= timestamp + ts_t'(1);
        end
    end

    // Low bits of the count act as slow square waves
    // Bit TCLK_BIT is taken at the top level as tclk
    // Each of its toggles is one DDR event for the tick generators

    // --------------------
    // Checks
    // --------------------

    // Steady one-per-cycle advance once out of reset
    // Includes the wrap from all ones back to zero
    a_ts_step : assert property (
        @(posedge clk) disable iff (srst)
        !$past(srst) |-> (timestamp == ts_t'($past(timestamp) + ts_t'(1)))
    );

endmodule : timestamp_gen

`default_nettype wire

/* sim/tb_timer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_timer_top
    import timer_pkg::*;
();

    // --------------------
    // Constants
    // --------------------

    localparam int NUM_RAND_CMDS = 120;
    localparam int FINE_PER      = 2 * FINE_DIV;
    localparam int COARSE_PER    = 2 * COARSE_DIV;
    // Longest run per command, coarse ticks at the top count
    localparam int TIMEOUT_CYC   = NUM_RAND_CMDS * 15 * COARSE_PER + 2000;

    // Model of one channel
    typedef struct packed {
        logic      run;
        tick_sel_t sel;
        tmr_cnt_t  rem;
        logic      exp;
    } chan_model_t;

    // --------------------
    // DUT signals
    // --------------------

    logic     clk;
    logic     srst;
    logic     cmd_valid;
    tmr_cmd_t cmd;
    logic     squelch;
    ts_t      timestamp;
    logic     fine_tick;
    logic     coarse_tick;
    tmr_vec_t expired;

    // Checker state
    chan_model_t mdl [NUM_TIMERS];
    tmr_vec_t    exp_pred;
    ts_t         ts_exp;
    logic        srst_prev;
    logic        squelch_prev;
    logic        fine_prev;
    logic        coarse_prev;
    int          cyc;
    int          last_fine;
    int          last_coarse;
    bit          fine_gap;
    bit          coarse_gap;
    int          fine_cnt;
    int          coarse_cnt;
    int          exp_cnt;
    logic [15:0] lfsr;

    timer_top u_timer_top (
        .clk         (clk),
        .srst        (srst),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .squelch     (squelch),
        .timestamp   (timestamp),
        .fine_tick   (fine_tick),
        .coarse_tick (coarse_tick),
        .expired     (expired)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // Helpers
    // --------------------

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "Stopped on first failure");
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output int unsigned v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | lfsr[0];
        end
    endtask

    // Expected next state of one channel for one cycle
    function automatic chan_model_t model_step(input chan_model_t m, input logic fine,
                                               input logic coarse, input logic load,
                                               input tmr_cmd_t c);
        chan_model_t n;
        logic        t;
        n     = m;
        n.exp = 1'b0;
        t     = m.sel ? coarse : fine;
        // Command beats a tick in the same cycle
        if (load) begin
            n.run = !c.stop;
            if (!c.stop) begin
                n.sel = c.tick_sel;
                n.rem = (c.count == '0) ? tmr_cnt_t'(1) : c.count;
            end
        end else if (m.run && t) begin
            if (m.rem == tmr_cnt_t'(1)) begin
                n.run = 1'b0;
                n.exp = 1'b1;
            end else begin
                n.rem = m.rem - tmr_cnt_t'(1);
            end
        end
        return n;
    endfunction

    function automatic logic model_busy();
        logic busy;
        busy = 1'b0;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            busy = busy | mdl[i].run;
        end
        return busy;
    endfunction

    // Width, squelch and period of one tick output
    task automatic check_tick(input string name, input logic t, input logic t_prev,
                              input int per, inout int last, inout bit gap, inout int cnt);
        if (squelch_prev) begin
            assert (!t) else fail_run($sformatf("ERR %0t: %s tick under squelch", $time, name));
            gap = 1'b1;
        end
        if (t) begin
            assert (!t_prev) else fail_run($sformatf("ERR %0t: %s tick too wide", $time, name));
            if (last >= 0 && !gap) begin
                assert (cyc - last == per)
                    else fail_run($sformatf("ERR %0t: %s period %0d, expected %0d",
                                            $time, name, cyc - last, per));
            end
            // Phase kept across squelch
            if (last >= 0 && gap) begin
                assert ((cyc - last) % per == 0)
                    else fail_run($sformatf("ERR %0t: %s phase lost, gap %0d",
                                            $time, name, cyc - last));
            end
            last = cyc;
            gap  = 1'b0;
            cnt++;
        end
    endtask

    // --------------------
    // Checker
    // --------------------

    // Mid-cycle sampling, inputs and outputs both settled
    always @(negedge clk) begin
        if (srst_prev) begin
            assert (timestamp == '0)
                else fail_run($sformatf("ERR %0t: timestamp %0d in reset", $time, timestamp));
        end else begin
            assert (timestamp == ts_exp)
                else fail_run($sformatf("ERR %0t: timestamp %0d, expected %0d",
                                        $time, timestamp, ts_exp));
            check_tick("fine", fine_tick, fine_prev, FINE_PER, last_fine, fine_gap, fine_cnt);
            check_tick("coarse", coarse_tick, coarse_prev, COARSE_PER, last_coarse,
                       coarse_gap, coarse_cnt);
        end
        assert (expired == exp_pred)
            else fail_run($sformatf("ERR %0t: expired %b, expected %b", $time, expired, exp_pred));
        exp_cnt += $countones(expired);
        // Model step for the coming edge
        for (int i = 0; i < NUM_TIMERS; i++) begin
            if (srst) begin
                mdl[i] = '0;
            end else begin
                mdl[i] = model_step(mdl[i], fine_tick, coarse_tick,
                                    cmd_valid && (cmd.id == tmr_id_t'(i)), cmd);
            end
            exp_pred[i] = mdl[i].exp;
        end
        // Cycle count since reset release
        ts_exp       = srst ? ts_t'(0) : ts_t'(ts_exp + ts_t'(1));
        srst_prev    = srst;
        squelch_prev = squelch;
        fine_prev    = fine_tick;
        coarse_prev  = coarse_tick;
        cyc++;
    end

    // Watchdog
    initial begin
        wait (cyc >= TIMEOUT_CYC);
        fail_run($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC));
    end

    // --------------------
    // Stimulus
    // --------------------

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic send_cmd(input int unsigned id, input logic stop, input logic sel,
                            input int unsigned count);
        cmd_valid    = 1'b1;
        cmd.id       = tmr_id_t'(id);
        cmd.stop     = stop;
        cmd.tick_sel = sel;
        cmd.count    = tmr_cnt_t'(count);
        next_cycle();
        cmd_valid    = 1'b0;
    endtask

    // Until every channel is idle, then let the last strobe be compared
    task automatic wait_idle();
        while (model_busy()) next_cycle();
        idle_cycles(2);
    endtask

    initial begin
        int unsigned id;
        int unsigned stp;
        int unsigned sel;
        int unsigned cnt;
        int unsigned gap;
        int unsigned sq;
        srst         = 1'b1;
        cmd_valid    = 1'b0;
        cmd          = '0;
        squelch      = 1'b0;
        exp_pred     = '0;
        srst_prev    = 1'b1;
        squelch_prev = 1'b0;
        ts_exp       = '0;
        fine_prev    = 1'b0;
        coarse_prev  = 1'b0;
        cyc          = 0;
        last_fine    = -1;
        last_coarse  = -1;
        fine_gap     = 1'b0;
        coarse_gap   = 1'b0;
        fine_cnt     = 0;
        coarse_cnt   = 0;
        exp_cnt      = 0;
        lfsr         = 16'd24;
        foreach (mdl[i]) mdl[i] = '0;
        repeat (8) @(posedge clk);
        #10;
        srst = 1'b0;
        idle_cycles(3);
        // Both sources, all channels, count of 0
        send_cmd(0, 1'b0, 1'b0, 3);
        send_cmd(1, 1'b0, 1'b1, 2);
        send_cmd(2, 1'b0, 1'b0, 0);
        send_cmd(3, 1'b0, 1'b1, 1);
        wait_idle();
        // Stop and restart while running
        send_cmd(0, 1'b0, 1'b0, 10);
        idle_cycles(25);
        send_cmd(0, 1'b1, 1'b0, 0);
        send_cmd(1, 1'b0, 1'b1, 5);
        idle_cycles(50);
        send_cmd(1, 1'b0, 1'b0, 2);
        wait_idle();
        // Squelch in the middle of a countdown
        send_cmd(2, 1'b0, 1'b1, 4);
        send_cmd(3, 1'b0, 1'b0, 9);
        idle_cycles(30);
        squelch = 1'b1;
        idle_cycles(65);
        squelch = 1'b0;
        wait_idle();
        // Random commands, stops about 1 in 8, squelch about 1 in 16
        for (int n = 0; n < NUM_RAND_CMDS; n++) begin
            take_bits(2, id);
            take_bits(3, stp);
            take_bits(1, sel);
            take_bits(4, cnt);
            take_bits(6, gap);
            take_bits(4, sq);
            if (cnt == 0) cnt = 1;
            send_cmd(id, stp == 0, sel[0], cnt);
            squelch = (sq == 0);
            idle_cycles(gap);
            squelch = 1'b0;
        end
        wait_idle();
        assert (fine_cnt > 0 && coarse_cnt > 0) else fail_run("No ticks were seen");
        assert (exp_cnt >= NUM_TIMERS) else fail_run("Too few timer expiries were seen");
        $display("sim passed");
        $finish;
    end

endmodule : tb_timer_top

`default_nettype wire

/* timer/timer_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_bank
    import timer_pkg::*;
(
    input  logic     clk,
    input  logic     srst,

    // Single-cycle command, always accepted
    input  logic     cmd_valid,
    input  tmr_cmd_t cmd,

    // Shared ticks
    input  logic     fine_tick,
    input  logic     coarse_tick,

    // Expiry strobes, one bit per channel
    output tmr_vec_t expired
);

    // --------------------
    // Decode
    // --------------------

    tmr_vec_t load_vec;

    // One-hot strobe from the channel id
    assign load_vec = cmd_valid ? (tmr_vec_t'(1) << cmd.id) : '0;

    // --------------------
    // Channels
    // --------------------

    // Command and ticks go to every channel
    // Only the addressed one sees load
    generate
        for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_chan
            timer_channel u_timer_channel (
                .clk         (clk),
                .srst        (srst),
                .load        (load_vec[i]),
                .cmd         (cmd),
                .fine_tick   (fine_tick),
                .coarse_tick (coarse_tick),
                .expired     (expired[i])
            );
        end
    endgenerate

    // --------------------
    // Checks
    // --------------------

    // Each command reaches exactly one channel
    a_load_onehot : assert property (
        @(posedge clk) disable iff (srst)
        cmd_valid |-> $onehot(load_vec)
    );

endmodule : timer_bank

`default_nettype wire

/* timer/timer_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_channel
    import timer_pkg::*;
(
    input  logic     clk,
    input  logic     srst,

    // Command strobe for this channel
    input  logic     load,
    input  tmr_cmd_t cmd,

    // Tick sources
    input  logic     fine_tick,
    input  logic     coarse_tick,

    // One-cycle expiry strobe
    output logic     expired
);

    // --------------------
    // Signals
    // --------------------

    tmr_state_e state;
    tmr_cnt_t   remaining;
    tick_sel_t  tick_sel_q;
    logic       sel_tick;
    logic       cnt_step;
    logic       last_tick;

    // Latched source, 1 picks the coarse tick
    assign sel_tick = tick_sel_q ? coarse_tick : fine_tick;

    // Load wins over a tick in the same cycle
    assign cnt_step  = (state == TMR_RUN) && sel_tick && !load;
    assign last_tick = cnt_step && (remaining == tmr_cnt_t'(TMR_CNT_MIN));

    // --------------------
    // State machine
    // --------------------

    always_ff @(posedge clk) begin
        if (srst) begin
            state   <= TMR_IDLE;
            expired <= 1'b0;
        end else begin
            expired <= 1'b0;
            if (load) begin
                // Stop cancels quietly, start or restart runs
                state <= cmd.stop ? TMR_IDLE : TMR_RUN;
            end else if (last_tick) begin
                state   <= TMR_IDLE;
                expired <= 1'b1;
            end
        end
    end

    // --------------------
    // Count
    // --------------------

    // Count of 0 runs as the minimum count
    always_ff @(posedge clk) begin
        if (load && !cmd.stop) begin
            remaining  <= (cmd.count == '0) ? tmr_cnt_t'(TMR_CNT_MIN) : cmd.count;
            tick_sel_q <= cmd.tick_sel;
        end else if (cnt_step) begin
            remaining  <= remaining - 1'b1;
        end
    end

    // --------------------
    // Checks
    // --------------------

    // Expiry only ends a run
    a_exp_after_run : assert property (
        @(posedge clk) disable iff (srst)
        expired |-> ($past(state) == TMR_RUN)
    );

    // A running count is never exhausted
    a_run_nonzero : assert property (
        @(posedge clk) disable iff (srst)
        (state == TMR_RUN) |-> (remaining != '0)
    );

endmodule : timer_channel

`default_nettype wire
